// ==== common/cpu_cfg_pkg.sv ====
package cpu_cfg_pkg;

    // Data path and register file
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int num_regs = 32;

    // Memory depths in 32-bit words
    localparam int imem_words = 256;
    localparam int dmem_words = 64;

    // Word indices into each memory, byte offset dropped
    typedef logic [$clog2(imem_words)-1:0] imem_addr_t;
    typedef logic [$clog2(dmem_words)-1:0] dmem_addr_t;

endpackage

// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcodes of the supported groups
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    // funct3, shared by register and immediate groups
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // Word-sized memory accesses only
    localparam logic [2:0] f3_lw = 3'b010;
    localparam logic [2:0] f3_sw = 3'b010;

    localparam logic [6:0] base_funct7 = 7'b0000000;
    localparam logic [6:0] alt_funct7  = 7'b0100000; // sub, sra, srai

    // R-type field layout; other formats reuse the same bits
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

endpackage

// ==== common/ctrl_if.sv ====
interface ctrl_if;
    import cpu_cfg_pkg::*;
    import rv_isa_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;       // Already sign-extended
    alu_op_t   alu_op;
    logic      use_imm;   // Second ALU operand from imm
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;

    modport dec (
        output rs1, rs2, rd, imm, alu_op, use_imm,
        output reg_write, mem_read, mem_write
    );

    modport exe (
        input alu_op, use_imm, imm
    );

    modport res (
        input rd, reg_write, mem_read, mem_write
    );

endinterface

// ==== hw/word_ram.sv ====
module word_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 64
) (
    input  logic                     CLK,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [depth];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Asynchronous read, same-cycle use by the core
    assign rdata = mem[raddr];

endmodule

// ==== hw/reg_file.sv ====
module reg_file (
    input  logic                  CLK,
    input  logic                  RST,
    input  cpu_cfg_pkg::reg_addr_t rs1,
    input  cpu_cfg_pkg::reg_addr_t rs2,
    input  cpu_cfg_pkg::reg_addr_t rd,
    input  cpu_cfg_pkg::word_t     wdata,
    input  logic                  we,
    output cpu_cfg_pkg::word_t     rdata1,
    output cpu_cfg_pkg::word_t     rdata2
);
    import cpu_cfg_pkg::*;

    word_t regs [num_regs];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= wdata;
        end
    end

    // x0 is hardwired regardless of array contents
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== core/decode_unit.sv ====
module decode_unit (
    input rv_isa_pkg::instr_t instr,
    ctrl_if.dec               ctl
);
    import cpu_cfg_pkg::*;
    import rv_isa_pkg::*;

    word_t imm_i;
    word_t imm_s;
    logic  reg_fields_ok;
    logic  imm_fields_ok;
    logic  shift_alt;

    function automatic alu_op_t alu_sel(logic [2:0] f3, logic alt);
        case (f3)
            f3_add_sub: return alt ? alu_sub : alu_add;
            f3_sll:     return alu_sll;
            f3_slt:     return alu_slt;
            f3_sltu:    return alu_sltu;
            f3_xor:     return alu_xor;
            f3_srl_sra: return alt ? alu_sra : alu_srl;
            f3_or:      return alu_or;
            default:    return alu_and;
        endcase
    endfunction

    assign imm_i = {{20{instr.funct7[6]}}, instr.funct7, instr.rs2}; // I format
    assign imm_s = {{20{instr.funct7[6]}}, instr.funct7, instr.rd};  // S format

    // Only add/sub and srl/sra accept the alternate funct7
    assign reg_fields_ok = (instr.funct7 == base_funct7) ||
                           ((instr.funct7 == alt_funct7) &&
                            (instr.funct3 == f3_add_sub || instr.funct3 == f3_srl_sra));

    // Upper immediate bits are free except for the shift forms
    always_comb begin
        case (instr.funct3)
            f3_sll:     imm_fields_ok = (instr.funct7 == base_funct7);
            f3_srl_sra: imm_fields_ok = (instr.funct7 == base_funct7) ||
                                        (instr.funct7 == alt_funct7);
            default:    imm_fields_ok = 1'b1;
        endcase
    end

    assign shift_alt = (instr.funct3 == f3_srl_sra) && instr.funct7[5]; // srai only

    always_comb begin
        ctl.rs1       = instr.rs1;
        ctl.rs2       = instr.rs2;
        ctl.rd        = instr.rd;
        ctl.imm       = imm_i;
        ctl.alu_op    = alu_add; // Also the address adder for lw/sw
        ctl.use_imm   = 1'b0;
        ctl.reg_write = 1'b0;
        ctl.mem_read  = 1'b0;
        ctl.mem_write = 1'b0;

        case (instr.opcode)
            op_reg: begin
                ctl.alu_op    = alu_sel(instr.funct3, instr.funct7[5]);
                ctl.reg_write = reg_fields_ok;
            end
            op_imm: begin
                ctl.use_imm   = 1'b1;
                ctl.alu_op    = alu_sel(instr.funct3, shift_alt);
                ctl.reg_write = imm_fields_ok;
            end
            op_load: begin
                ctl.use_imm   = 1'b1;
                ctl.reg_write = (instr.funct3 == f3_lw);
                ctl.mem_read  = (instr.funct3 == f3_lw);
            end
            op_store: begin
                ctl.use_imm   = 1'b1;
                ctl.imm       = imm_s;
                ctl.mem_write = (instr.funct3 == f3_sw);
            end
            default: ; // Unsupported, retires as no-op
        endcase
    end

endmodule

// ==== core/execute_unit.sv ====
module execute_unit (
    ctrl_if.exe                ctl,
    input  cpu_cfg_pkg::word_t op_a,
    input  cpu_cfg_pkg::word_t op_b,
    output cpu_cfg_pkg::word_t result
);
    import cpu_cfg_pkg::*;
    import rv_isa_pkg::*;

    word_t      src_b;
    logic [4:0] shamt;

    assign src_b = ctl.use_imm ? ctl.imm : op_b;
    assign shamt = src_b[4:0]; // RV32 shifts ignore upper bits

    always_comb begin
        case (ctl.alu_op)
            alu_add:  result = op_a + src_b;
            alu_sub:  result = op_a - src_b;
            alu_sll:  result = op_a << shamt;
            alu_slt:  result = word_t'($signed(op_a) < $signed(src_b));
            alu_sltu: result = word_t'(op_a < src_b);
            alu_xor:  result = op_a ^ src_b;
            alu_srl:  result = op_a >> shamt;
            alu_sra:  result = word_t'($signed(op_a) >>> shamt);
            alu_or:   result = op_a | src_b;
            alu_and:  result = op_a & src_b;
            default:  result = '0;
        endcase
    end

endmodule

// ==== core/result_unit.sv ====
module result_unit (
    ctrl_if.res                        ctl,
    input  cpu_cfg_pkg::word_t         alu_result,
    input  cpu_cfg_pkg::word_t         load_data,
    input  cpu_cfg_pkg::word_t         store_src,
    output logic                       wb_en,
    output cpu_cfg_pkg::reg_addr_t     wb_rd,
    output cpu_cfg_pkg::word_t         wb_data,
    output logic                       store_en,
    output cpu_cfg_pkg::dmem_addr_t    store_addr,
    output cpu_cfg_pkg::word_t         store_data,
    output cpu_cfg_pkg::dmem_addr_t    load_addr
);
    import cpu_cfg_pkg::*;

    dmem_addr_t word_idx;

    // Drop byte offset, upper bits wrap the index
    assign word_idx = alu_result[$bits(dmem_addr_t)+1:2];

    assign wb_en   = ctl.reg_write && (ctl.rd != '0); // x0 stays zero
    assign wb_rd   = ctl.rd;
    assign wb_data = ctl.mem_read ? load_data : alu_result;

    assign store_en   = ctl.mem_write;
    assign store_addr = word_idx;
    assign store_data = store_src; // rs2 value

    assign load_addr = word_idx;

endmodule

// ==== hw/single_cpu.sv ====
module single_cpu (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    load_en,
    input  cpu_cfg_pkg::imem_addr_t load_addr,
    input  cpu_cfg_pkg::word_t      load_data,
    output cpu_cfg_pkg::word_t      pc,
    output logic                    retire,
    output logic                    wb_en,
    output cpu_cfg_pkg::reg_addr_t  wb_rd,
    output cpu_cfg_pkg::word_t      wb_data,
    output logic                    store_en,
    output cpu_cfg_pkg::dmem_addr_t store_addr,
    output cpu_cfg_pkg::word_t      store_data
);
    import cpu_cfg_pkg::*;
    import rv_isa_pkg::*;

    instr_t     instr;
    imem_addr_t fetch_idx;
    word_t      op_a;
    word_t      op_b;
    word_t      alu_result;
    word_t      dmem_rdata;
    dmem_addr_t dmem_raddr;
    logic       core_wb_en;
    logic       core_store_en;

    ctrl_if ctl ();

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // One instruction completes every cycle out of reset
    assign retire    = !RST;
    assign fetch_idx = pc[$bits(imem_addr_t)+1:2];

    // Program loading only while held in reset
    word_ram #(
        .entry_t (instr_t),
        .depth   (imem_words)
    ) imem (
        .CLK   (CLK),
        .we    (load_en && RST),
        .waddr (load_addr),
        .wdata (instr_t'(load_data)),
        .raddr (fetch_idx),
        .rdata (instr)
    );

    decode_unit u_decode (
        .instr (instr),
        .ctl   (ctl.dec)
    );

    reg_file u_regs (
        .CLK    (CLK),
        .RST    (RST),
        .rs1    (ctl.rs1),
        .rs2    (ctl.rs2),
        .rd     (wb_rd),
        .wdata  (wb_data),
        .we     (wb_en),
        .rdata1 (op_a),
        .rdata2 (op_b)
    );

    execute_unit u_execute (
        .ctl    (ctl.exe),
        .op_a   (op_a),
        .op_b   (op_b),
        .result (alu_result)
    );

    result_unit u_result (
        .ctl        (ctl.res),
        .alu_result (alu_result),
        .load_data  (dmem_rdata),
        .store_src  (op_b),
        .wb_en      (core_wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .store_en   (core_store_en),
        .store_addr (store_addr),
        .store_data (store_data),
        .load_addr  (dmem_raddr)
    );

    // Whatever sits at pc 0 during loading must not commit
    assign wb_en    = core_wb_en && retire;
    assign store_en = core_store_en && retire;

    word_ram #(
        .entry_t (word_t),
        .depth   (dmem_words)
    ) dmem (
        .CLK   (CLK),
        .we    (store_en),
        .waddr (store_addr),
        .wdata (store_data),
        .raddr (dmem_raddr),
        .rdata (dmem_rdata)
    );

endmodule

// ==== bench/single_cpu_props.sv ====
module single_cpu_props (
    input logic                   CLK,
    input logic                   RST,
    input cpu_cfg_pkg::word_t     pc,
    input logic                   wb_en,
    input cpu_cfg_pkg::reg_addr_t wb_rd,
    input logic                   store_en
);

    quiet_in_reset: assert property (@(posedge CLK) RST |-> (!wb_en && !store_en))
        else $error("wb_en or store_en high during reset");

    // First cycle out of reset has no previous pc to compare
    pc_step: assert property (@(posedge CLK) disable iff (RST)
        !$past(RST) |-> (pc == $past(pc) + 32'd4))
        else $error("pc did not advance by 4");

    no_x0_write: assert property (@(posedge CLK) wb_en |-> (wb_rd != '0))
        else $error("write-back to x0");

    one_effect: assert property (@(posedge CLK) !(store_en && wb_en))
        else $error("store and write-back in the same cycle");

endmodule

bind single_cpu single_cpu_props props0 (
    .CLK      (CLK),
    .RST      (RST),
    .pc       (pc),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .store_en (store_en)
);

// ==== bench/tb_single_cpu.sv ====
module tb_single_cpu;
    import cpu_cfg_pkg::*;

    localparam int retire_timeout = 20;
    localparam int num_random     = 180; // Supported instructions after the data setup stores

    logic       CLK;
    logic       RST;
    logic       load_en;
    imem_addr_t load_addr;
    word_t      load_data;
    word_t      pc;
    logic       retire;
    logic       wb_en;
    reg_addr_t  wb_rd;
    word_t      wb_data;
    logic       store_en;
    dmem_addr_t store_addr;
    word_t      store_data;

    word_t prog [imem_words];
    word_t mregs [32];         // Architectural registers of the model
    word_t mmem [dmem_words];  // Data words of the model

    string      kind;
    logic       exp_wb_en;
    reg_addr_t  exp_rd;
    word_t      exp_wb_data;
    logic       exp_st_en;
    dmem_addr_t exp_st_addr;
    word_t      exp_st_data;

    int mismatches = 0;
    int timeouts = 0;
    int checked = 0;

    single_cpu dut0 (
        .CLK        (CLK),
        .RST        (RST),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .pc         (pc),
        .retire     (retire),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data)
    );

    always #4 CLK = ~CLK;

    // I and S immediates travel in the R-format slots
    function automatic word_t encode_fields(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic word_t random_instr();
        int         sel;
        logic [2:0] f3;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] imm;
        logic [11:0] off;
        sel = $urandom_range(0, 9);
        f3  = 3'($urandom_range(0, 7));
        rd  = ($urandom_range(0, 9) == 0) ? 5'd0 : 5'($urandom_range(0, 31)); // Some x0 targets
        rs1 = 5'($urandom_range(0, 31));
        rs2 = 5'($urandom_range(0, 31));
        imm = 12'($urandom_range(0, 4095));
        off = 12'($urandom_range(0, 15) * 4); // Words 0 to 15
        if (sel < 4) begin
            return encode_fields(((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1)) ?
                                 7'h20 : 7'h00,
                                 rs2, rs1, f3, rd, 7'h33);
        end else if (sel < 7) begin
            if (f3 == 3'd1) begin
                imm[11:5] = 7'h00;
            end else if (f3 == 3'd5) begin
                imm[11:5] = $urandom_range(0, 1) ? 7'h20 : 7'h00; // srai or srli
            end
            return encode_fields(imm[11:5], imm[4:0], rs1, f3, rd, 7'h13);
        end else if (sel == 7) begin
            return encode_fields(off[11:5], off[4:0], 5'd0, 3'd2, rd, 7'h03);
        end
        rs1 = $urandom_range(0, 1) ? 5'd0 : rs1; // Random base wraps modulo 64
        return encode_fields(off[11:5], rs2, rs1, 3'd2, off[4:0], 7'h23);
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic execute_model(input word_t w);
        logic [6:0] f7;
        logic [2:0] f3;
        logic       wr;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      ea;
        word_t      val;
        f7    = w[31:25];
        f3    = w[14:12];
        a     = mregs[w[19:15]];
        b     = mregs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        wr    = 1'b0;
        val   = '0;
        kind  = "noop";
        exp_st_en = 1'b0;
        case (w[6:0])
            7'h33: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    kind = "alu_r";
                    wr   = 1'b1;
                    val  = alu_model(f3, f7[5], a, b);
                end
            end
            7'h13: begin
                if (!(f3 == 3'd1 && f7 != 7'h00) &&
                    !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
                    kind = "alu_i";
                    wr   = 1'b1;
                    val  = alu_model(f3, (f3 == 3'd5) && f7[5], a, imm_i); // No subi
                end
            end
            7'h03: begin
                if (f3 == 3'd2) begin
                    kind = "lw";
                    ea   = a + imm_i;
                    wr   = 1'b1;
                    val  = mmem[ea[7:2]];
                end
            end
            7'h23: begin
                if (f3 == 3'd2) begin
                    kind        = "sw";
                    ea          = a + imm_s;
                    exp_st_en   = 1'b1;
                    exp_st_addr = ea[7:2];
                    exp_st_data = b;
                end
            end
            default: ;
        endcase
        exp_wb_en   = wr && (w[11:7] != 5'd0);
        exp_rd      = w[11:7];
        exp_wb_data = val;
        if (exp_wb_en) begin
            mregs[exp_rd] = val;
        end
        if (exp_st_en) begin
            mmem[exp_st_addr] = exp_st_data;
        end
    endtask

    task automatic compare_word(input string test, input string field, input int idx,
                                input word_t exp, input word_t act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s.%s at instr %0d: expected 0x%08h, actual 0x%08h",
                     test, field, idx, exp, act);
        end
    endtask

    task automatic wait_for_retire(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < retire_timeout) begin
            @(negedge CLK);
            if (retire === 1'b1) begin
                ok = 1'b1;
            end else begin
                cycles++;
            end
        end
    endtask

    initial begin
        bit          ok;
        word_t       r;
        logic [11:0] off;
        r = $urandom(56);
        CLK       = 1'b0;
        RST       = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end

        for (int i = 0; i < 16; i++) begin
            off = 12'(i * 4);
            prog[i] = encode_fields(off[11:5], 5'd0, 5'd0, 3'd2, off[4:0], 7'h23); // sw x0
        end
        for (int i = 16; i < 16 + num_random; i++) begin
            prog[i] = random_instr();
        end
        prog[196] = '0;
        r = $urandom();
        prog[197] = {r[31:7], 7'b1100011}; // Branch
        r = $urandom();
        prog[198] = {r[31:7], 7'b0110111}; // lui
        r = $urandom();
        prog[199] = encode_fields(7'h01, r[24:20], r[19:15], r[14:12], r[11:7], 7'h33); // M ext
        for (int i = 200; i < imem_words; i++) begin
            prog[i] = '0;
        end

        repeat (8) @(posedge CLK);
        // Loading continues with RST still high
        for (int i = 0; i < imem_words; i++) begin
            @(posedge CLK);
            load_en   <= 1'b1;
            load_addr <= imem_addr_t'(i);
            load_data <= prog[i];
        end
        @(posedge CLK);
        load_en <= 1'b0;
        RST     <= 1'b0;

        for (int k = 0; k < imem_words; k++) begin
            wait_for_retire(ok);
            if (!ok) begin
                timeouts++;
                $display("Timeout: retire stayed low before instruction %0d", k);
                break;
            end
            compare_word("pc", "pc", k, word_t'(4 * k), pc);
            execute_model(prog[k]);
            compare_word(kind, "wb_en", k, word_t'(exp_wb_en), word_t'(wb_en));
            if (exp_wb_en) begin
                compare_word(kind, "wb_rd", k, word_t'(exp_rd), word_t'(wb_rd));
                compare_word(kind, "wb_data", k, exp_wb_data, wb_data);
            end
            compare_word(kind, "store_en", k, word_t'(exp_st_en), word_t'(store_en));
            if (exp_st_en) begin
                compare_word(kind, "store_addr", k, word_t'(exp_st_addr), word_t'(store_addr));
                compare_word(kind, "store_data", k, exp_st_data, store_data);
            end
            checked++;
        end

        $display("Checked %0d instructions, %0d mismatches, %0d timeouts",
                 checked, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/cpu_cfg_pkg.sv
common/rv_isa_pkg.sv
common/ctrl_if.sv
hw/word_ram.sv
hw/reg_file.sv
core/decode_unit.sv
core/execute_unit.sv
core/result_unit.sv
hw/single_cpu.sv
bench/single_cpu_props.sv
bench/tb_single_cpu.sv
